//--- Makefile
TOP = video_out_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

//--- sources.f
video_pkg.sv
video_clk_en_gen.sv
tms9918_scandoubler.sv
vga_pixel_out.sv
video_out_top.sv
tb_clk_gen.sv
video_out_checker.sv
video_out_tb.sv

//--- tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
   output logic clk_o,
   output logic arst_n_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;   // 10 ns period
   end

   // reset held over the first two rising edges
   initial begin
      arst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      #2 arst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

//--- tms9918_scandoubler.sv
`timescale 1ns/100ps
`default_nettype none

module tms9918_scandoubler (
   input  wire logic                clk,
   input  wire logic                arst_n_i,
   input  wire logic                vdp_clk_en_i,
   input  wire logic                vga_clk_en_i,
   input  wire video_pkg::vdp_pix_t pix_i,
   output video_pkg::vga_pix_t      pix_o
);

   // entry: {sync_h, color_en, color}
   logic [5:0] line_mem [2][video_pkg::LINE_LEN];

   logic                               bank_q;          // bank being written
   logic                               started_q;
   logic                               sync_h_prev_q;
   logic [video_pkg::LINE_IDX_W-1:0]   wr_idx_q;
   logic [video_pkg::LINE_IDX_W-1:0]   rd_idx_q;

   logic                               line_start;
   logic                               wr_bank;
   logic                               wr_en;
   logic                               rd_valid;
   logic [video_pkg::LINE_IDX_W-1:0]   wr_idx;
   logic [video_pkg::LINE_IDX_W-1:0]   rd_idx;
   logic [5:0]                         rd_ent;

   logic                               sync_h_q;
   logic                               color_en_q;
   logic                               sync_v_q;
   logic [3:0]                         color_q;

   // rising edge of hsync, seen at vdp pixel rate
   assign line_start = vdp_clk_en_i && pix_i.sync_h && !sync_h_prev_q;

   // on a line start both sides restart at entry 0 of the swapped banks
   assign wr_bank = line_start ? ~bank_q : bank_q;
   assign wr_idx  = line_start ? '0 : wr_idx_q;
   assign rd_idx  = line_start ? '0 : rd_idx_q;

   assign wr_en    = vdp_clk_en_i && (wr_idx != video_pkg::LINE_END);   // overlong line dropped
   assign rd_valid = started_q || line_start;
   assign rd_ent   = line_mem[~wr_bank][rd_idx];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         bank_q        <= 1'b0;
         started_q     <= 1'b0;
         sync_h_prev_q <= 1'b0;
         wr_idx_q      <= '0;
         rd_idx_q      <= '0;
      end else begin
         if (vdp_clk_en_i)
            sync_h_prev_q <= pix_i.sync_h;
         if (wr_en)
            wr_idx_q <= wr_idx + 1'b1;
         if (line_start) begin
            bank_q    <= ~bank_q;
            started_q <= 1'b1;
         end
         // read side wraps, so the stored line plays twice
         if (vga_clk_en_i) begin
            if (rd_idx == video_pkg::LINE_LAST)
               rd_idx_q <= '0;
            else
               rd_idx_q <= rd_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en)
         line_mem[wr_bank][wr_idx] <= {pix_i.sync_h, pix_i.color_en, pix_i.color};
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sync_h_q   <= 1'b0;
         color_en_q <= 1'b0;
         sync_v_q   <= 1'b0;
      end else if (vga_clk_en_i) begin
         sync_h_q   <= rd_valid && rd_ent[5];   // nothing stored before first swap
         color_en_q <= rd_valid && rd_ent[4];
         sync_v_q   <= pix_i.sync_v;            // vsync bypasses the buffers
      end
   end

   always_ff @(posedge clk) begin
      if (vga_clk_en_i)
         color_q <= rd_ent[3:0];
   end

   assign pix_o = '{sync_h: sync_h_q, sync_v: sync_v_q, color_en: color_en_q, color: color_q};

   // an input line never outgrows the buffer
   a_wr_idx_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
      vdp_clk_en_i && (wr_idx_q == video_pkg::LINE_END) |-> line_start);

   // the read side wraps to entry 0 just as a full line has been written
   a_line_align: assert property (@(posedge clk) disable iff (!arst_n_i)
      line_start && started_q |-> (rd_idx_q == '0) && (wr_idx_q == video_pkg::LINE_END));

endmodule

`default_nettype wire

//--- vga_pixel_out.sv
`timescale 1ns/100ps
`default_nettype none

module vga_pixel_out (
   input  wire logic                clk,
   input  wire logic                arst_n_i,
   input  wire logic                vga_clk_en_i,
   input  wire video_pkg::vga_pix_t pix_i,
   input  wire logic [3:0]          overlay_color_i,
   output video_pkg::rgb12_t        rgb_o,
   output logic                     hsync_o,
   output logic                     vsync_o
);

   logic       upd_q;       // vga strobe, one clock late
   logic       hs_q;
   logic       vs_q;
   logic [3:0] color_idx;

   video_pkg::rgb12_t rgb_d;

   always_comb begin
      if (overlay_color_i != 4'd0)
         color_idx = overlay_color_i;   // service processor overlay on top
      else if (pix_i.color_en)
         color_idx = pix_i.color;
      else
         color_idx = 4'd0;              // blanking shows black
   end

   assign rgb_d = video_pkg::TMS9918_PALETTE[color_idx];

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         upd_q <= 1'b0;
         rgb_o <= '0;
         hs_q  <= 1'b0;
         vs_q  <= 1'b0;
      end else begin
         upd_q <= vga_clk_en_i;
         if (upd_q) begin
            rgb_o <= rgb_d;
            hs_q  <= pix_i.sync_h;
            vs_q  <= pix_i.sync_v;
         end
      end
   end

   // vga connector syncs are active low
   assign hsync_o = ~hs_q;
   assign vsync_o = ~vs_q;

endmodule

`default_nettype wire

//--- video_clk_en_gen.sv
`timescale 1ns/100ps
`default_nettype none

module video_clk_en_gen (
   input  wire logic clk,
   input  wire logic arst_n_i,
   output logic      vdp_clk_en_o,
   output logic      vga_clk_en_o
);

   logic [video_pkg::PHASE_W-1:0] phase_q;   // position within one vdp pixel
   logic                          vga_hit;
   logic                          vdp_hit;

   // vga pixel ends on every odd phase, vdp pixel on the last one
   assign vga_hit = (phase_q & video_pkg::VGA_PHASE_MASK) == video_pkg::VGA_PHASE_MASK;
   assign vdp_hit = phase_q == video_pkg::VDP_PHASE_LAST;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         phase_q      <= '0;
         vga_clk_en_o <= 1'b0;
         vdp_clk_en_o <= 1'b0;
      end else begin
         if (phase_q == video_pkg::VDP_PHASE_LAST)
            phase_q <= '0;
         else
            phase_q <= phase_q + 1'b1;
         vga_clk_en_o <= vga_hit;   // registered, first pulse on 2nd clock
         vdp_clk_en_o <= vdp_hit;
      end
   end

   // every vdp pixel boundary is also a vga pixel boundary
   a_vdp_in_vga: assert property (@(posedge clk) disable iff (!arst_n_i)
      vdp_clk_en_o |-> vga_clk_en_o);

endmodule

`default_nettype wire

//--- video_out_checker.sv
`timescale 1ns/100ps
`default_nettype none

module video_out_checker (
   input wire logic                clk,
   input wire logic                arst_n_i,
   input wire logic                vdp_clk_en_i,
   input wire video_pkg::vdp_pix_t vdp_pix_i,
   input wire logic [3:0]          overlay_color_i,
   input wire logic [3:0]          row_base_i,
   input wire logic [7:0]          row_width_i,
   input wire logic [8:0]          row_en_start_i,
   input wire logic [8:0]          row_en_end_i,
   input wire logic [3:0]          vga_r_i,
   input wire logic [3:0]          vga_g_i,
   input wire logic [3:0]          vga_b_i,
   input wire logic                vga_hs_i,
   input wire logic                vga_vs_i
);

   int pass_cnt = 0;
   int fail_cnt = 0;
   int rst_err  = 0;
   int en_err   = 0;
   int clks     = 0;   // rising edges since reset release
   int line_cnt = 0;
   int pair_err = 0;
   int d        = 0;   // falling edges since the last line start

   logic       prev_sh = 1'b0;
   logic       sv_d1   = 1'b0;
   logic       sv_d2   = 1'b0;
   logic [3:0] ov_d1   = 4'd0;   // overlay as seen at the output update edge

   // row being written now, and row being replayed
   logic [3:0] held_base, rep_base;
   logic [7:0] held_width, rep_width;
   logic [8:0] held_en_s, rep_en_s;
   logic [8:0] held_en_e, rep_en_e;

   function automatic logic [3:0] stripe_color(input logic [3:0] base, input logic [7:0] width,
                                               input int pos);
      return 4'(int'(base) + pos / int'(width));
   endfunction

   task automatic check_pixel(input int q);
      int                pos;
      logic              exp_sh;
      logic              exp_en;
      logic [3:0]        idx;
      logic [11:0]       got;
      video_pkg::rgb12_t exp_rgb;
      pos    = q % video_pkg::LINE_LEN;
      exp_sh = pos < video_pkg::HSYNC_LEN;
      exp_en = (pos >= int'(rep_en_s)) && (pos <= int'(rep_en_e));
      if (ov_d1 != 4'd0)
         idx = ov_d1;
      else if (exp_en)
         idx = stripe_color(rep_base, rep_width, pos);
      else
         idx = 4'd0;
      exp_rgb = video_pkg::TMS9918_PALETTE[idx];
      got     = {vga_r_i, vga_g_i, vga_b_i};
      if (got != exp_rgb || vga_hs_i != !exp_sh || vga_vs_i != !sv_d2) begin
         if (pair_err < 3)
            $display("[FAIL] %0t: row %0d pos %0d copy %0d: rgb %h hs %b vs %b, expected %h %b %b",
                     $time, line_cnt - 2, pos, q / video_pkg::LINE_LEN, got, vga_hs_i, vga_vs_i,
                     exp_rgb, !exp_sh, !sv_d2);
         pair_err++;
      end
   endtask

   task automatic finish_pair();
      if (pair_err == 0) begin
         pass_cnt++;
         $display("row %0d: line pair ok", line_cnt - 2);
      end else begin
         fail_cnt++;
         $display("row %0d: line pair has %0d wrong pixels", line_cnt - 2, pair_err);
      end
   endtask

   always @(negedge clk) begin
      if (!arst_n_i) begin
         if ({vga_r_i, vga_g_i, vga_b_i} != 12'h000 || !vga_hs_i || !vga_vs_i) begin
            $display("[FAIL] %0t: during reset rgb %h hs %b vs %b", $time,
                     {vga_r_i, vga_g_i, vga_b_i}, vga_hs_i, vga_vs_i);
            rst_err++;
         end
      end else begin
         // vdp strobe follows every fourth rising edge after reset release
         if (vdp_clk_en_i != (clks >= video_pkg::VDP_DIV && clks % video_pkg::VDP_DIV == 0)) begin
            if (en_err < 3)
               $display("[FAIL] %0t: vdp_clk_en %b after %0d clocks", $time, vdp_clk_en_i, clks);
            en_err++;
         end
         clks++;
         // entry q shows from the second edge after its vga strobe
         if (line_cnt >= 2 && d % 2 == 1 && d < 4 * video_pkg::LINE_LEN)
            check_pixel((d - 1) / 2);
         if (vdp_clk_en_i && vdp_pix_i.sync_h && !prev_sh) begin
            if (line_cnt >= 2)
               finish_pair();
            rep_base   = held_base;
            rep_width  = held_width;
            rep_en_s   = held_en_s;
            rep_en_e   = held_en_e;
            held_base  = row_base_i;
            held_width = row_width_i;
            held_en_s  = row_en_start_i;
            held_en_e  = row_en_end_i;
            line_cnt++;
            pair_err = 0;
            d        = 0;
         end else begin
            d++;
         end
         if (vdp_clk_en_i)
            prev_sh = vdp_pix_i.sync_h;
         sv_d2 = sv_d1;
         sv_d1 = vdp_pix_i.sync_v;
         ov_d1 = overlay_color_i;
      end
   end

endmodule

`default_nettype wire

//--- video_out_tb.sv
`timescale 1ns/100ps
`default_nettype none

module video_out_tb;

   localparam int NROWS      = 12;
   localparam int TIMEOUT_NS = (NROWS + 2) * video_pkg::LINE_LEN * video_pkg::VDP_DIV * 10 + 5000;

   logic                clk;
   logic                arst_n;
   logic                vdp_clk_en;
   logic [3:0]          overlay;
   logic [3:0]          vga_r, vga_g, vga_b;
   logic                vga_hs, vga_vs;
   video_pkg::vdp_pix_t vdp_pix;

   logic [3:0] cur_base;
   logic [7:0] cur_width;
   logic [8:0] cur_en_s;
   logic [8:0] cur_en_e;

   // stimulus table, one row per vdp line
   logic [3:0] tbl_base [NROWS];
   logic [7:0] tbl_width [NROWS];
   logic [3:0] tbl_ov [NROWS];
   logic [8:0] tbl_en_s [NROWS];
   logic [8:0] tbl_en_e [NROWS];
   logic       tbl_sv [NROWS];

   int seed;
   int passes;
   int fails;

   tb_clk_gen clk_gen0 (.clk_o(clk), .arst_n_o(arst_n));

   video_out_top dut0 (
      .clk             (clk),
      .arst_n_i        (arst_n),
      .vdp_pix_i       (vdp_pix),
      .overlay_color_i (overlay),
      .vdp_clk_en_o    (vdp_clk_en),
      .vga_r_o         (vga_r),
      .vga_g_o         (vga_g),
      .vga_b_o         (vga_b),
      .vga_hs_o        (vga_hs),
      .vga_vs_o        (vga_vs)
   );

   video_out_checker checker0 (
      .clk             (clk),
      .arst_n_i        (arst_n),
      .vdp_clk_en_i    (vdp_clk_en),
      .vdp_pix_i       (vdp_pix),
      .overlay_color_i (overlay),
      .row_base_i      (cur_base),
      .row_width_i     (cur_width),
      .row_en_start_i  (cur_en_s),
      .row_en_end_i    (cur_en_e),
      .vga_r_i         (vga_r),
      .vga_g_i         (vga_g),
      .vga_b_i         (vga_b),
      .vga_hs_i        (vga_hs),
      .vga_vs_i        (vga_vs)
   );

   function automatic logic [3:0] pixel_color(input logic [3:0] base, input logic [7:0] width,
                                              input int pos);
      return 4'(int'(base) + pos / int'(width));   // stripes step the color index
   endfunction

   task automatic set_row(input int r, input logic [3:0] base, input logic [7:0] width,
                          input logic [3:0] ov, input logic [8:0] en_s, input logic [8:0] en_e,
                          input logic sv);
      tbl_base[r]  = base;
      tbl_width[r] = width;
      tbl_ov[r]    = ov;
      tbl_en_s[r]  = en_s;
      tbl_en_e[r]  = en_e;
      tbl_sv[r]    = sv;
   endtask

   // the vdp pixel is taken on the edge after vdp_clk_en
   task automatic wait_pixel_taken();
      @(negedge clk);
      while (!vdp_clk_en)
         @(negedge clk);
      @(posedge clk);
      #1;
   endtask

   task automatic drive_line(input int r);
      int p;
      cur_base  = tbl_base[r];
      cur_width = tbl_width[r];
      cur_en_s  = tbl_en_s[r];
      cur_en_e  = tbl_en_e[r];
      overlay   = tbl_ov[r];
      for (p = 0; p < video_pkg::LINE_LEN; p++) begin
         vdp_pix = '{sync_h: p < video_pkg::HSYNC_LEN, sync_v: tbl_sv[r],
                     color_en: (p >= int'(tbl_en_s[r])) && (p <= int'(tbl_en_e[r])),
                     color: pixel_color(tbl_base[r], tbl_width[r], p)};
         wait_pixel_taken();
      end
   endtask

   initial begin
      vdp_pix   = '0;
      overlay   = 4'd0;
      cur_base  = 4'd0;
      cur_width = 8'd1;
      cur_en_s  = 9'd0;
      cur_en_e  = 9'd0;
      seed      = 32'h1cd2;
      set_row(0, 4'd0, 8'd16, 4'd0, 9'd30, 9'd330, 1'b1);   // walks all 16 colors
      set_row(1, 4'd5, 8'd7, 4'd0, 9'd40, 9'd300, 1'b1);
      set_row(2, 4'd9, 8'd3, 4'd12, 9'd26, 9'd341, 1'b0);
      set_row(3, 4'd2, 8'd20, 4'd0, 9'd100, 9'd200, 1'b0);  // wide blanking
      set_row(4, 4'd15, 8'd1, 4'd3, 9'd0, 9'd0, 1'b0);
      set_row(5, 4'd7, 8'd11, 4'd0, 9'd26, 9'd320, 1'b1);
      for (int r = NROWS / 2; r < NROWS; r++) begin
         tbl_base[r]  = 4'($random(seed));
         tbl_width[r] = 8'(($random(seed) & 15) + 1);
         tbl_en_s[r]  = 9'(26 + ($random(seed) & 63));
         tbl_en_e[r]  = 9'(200 + ($random(seed) & 127));
         tbl_ov[r]    = (($random(seed) & 3) == 0) ? 4'($random(seed)) : 4'd0;
         tbl_sv[r]    = 1'($random(seed));
      end
      wait (arst_n);
      $display("reset: %s", (checker0.rst_err == 0) ? "outputs ok" : "outputs wrong");
      @(posedge clk);
      #1;
      // two extra lines flush the replay of the last rows
      for (int r = 0; r < NROWS + 2; r++)
         drive_line(r % NROWS);
      repeat (4) @(negedge clk);
      $display("clock enable: %s", (checker0.en_err == 0) ? "timing ok" : "timing wrong");
      passes = checker0.pass_cnt + ((checker0.rst_err == 0) ? 1 : 0)
               + ((checker0.en_err == 0) ? 1 : 0);
      fails  = checker0.fail_cnt + ((checker0.rst_err == 0) ? 0 : 1)
               + ((checker0.en_err == 0) ? 0 : 1);
      $display("%0d tests passed, %0d tests failed", passes, fails);
      if (fails == 0 && checker0.pass_cnt == NROWS)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: the video lines did not finish in %0d ns", TIMEOUT_NS);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- video_out_top.sv
`timescale 1ns/100ps
`default_nettype none

module video_out_top (
   input  wire logic                clk,
   input  wire logic                arst_n_i,
   input  wire video_pkg::vdp_pix_t vdp_pix_i,
   input  wire logic [3:0]          overlay_color_i,
   output wire logic                vdp_clk_en_o,   // vdp presents next pixel after this
   output wire logic [3:0]          vga_r_o,
   output wire logic [3:0]          vga_g_o,
   output wire logic [3:0]          vga_b_o,
   output wire logic                vga_hs_o,
   output wire logic                vga_vs_o
);

   logic                vga_clk_en;
   video_pkg::vga_pix_t dbl_pix;    // doubled pixel at vga rate

   video_clk_en_gen clk_en_gen (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .vdp_clk_en_o (vdp_clk_en_o),
      .vga_clk_en_o (vga_clk_en)
   );

   tms9918_scandoubler scandoubler (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .vdp_clk_en_i (vdp_clk_en_o),
      .vga_clk_en_i (vga_clk_en),
      .pix_i        (vdp_pix_i),
      .pix_o        (dbl_pix)
   );

   vga_pixel_out pix_out (
      .clk             (clk),
      .arst_n_i        (arst_n_i),
      .vga_clk_en_i    (vga_clk_en),
      .pix_i           (dbl_pix),
      .overlay_color_i (overlay_color_i),
      .rgb_o           ({vga_r_o, vga_g_o, vga_b_o}),
      .hsync_o         (vga_hs_o),
      .vsync_o         (vga_vs_o)
   );

endmodule

`default_nettype wire

//--- video_pkg.sv
`default_nettype none

package video_pkg;

   // line timing, counted in vdp pixels
   localparam int LINE_LEN  = 342;   // incl. blanking
   localparam int HSYNC_LEN = 26;

   // clocks per pixel
   localparam int VDP_DIV = 4;
   localparam int VGA_DIV = 2;       // half of VDP_DIV

   localparam int PHASE_W    = $clog2(VDP_DIV);
   localparam int LINE_IDX_W = $clog2(LINE_LEN + 1);

   localparam logic [PHASE_W-1:0] VGA_PHASE_MASK = PHASE_W'(VGA_DIV - 1);
   localparam logic [PHASE_W-1:0] VDP_PHASE_LAST = PHASE_W'(VDP_DIV - 1);

   localparam logic [LINE_IDX_W-1:0] LINE_LAST = LINE_IDX_W'(LINE_LEN - 1);
   localparam logic [LINE_IDX_W-1:0] LINE_END  = LINE_IDX_W'(LINE_LEN);

   typedef struct packed {
      logic       sync_h;
      logic       sync_v;
      logic       color_en;   // active area
      logic [3:0] color;
   } vdp_pix_t;

   // same fields, but one pixel of the doubled vga line
   typedef struct packed {
      logic       sync_h;
      logic       sync_v;
      logic       color_en;
      logic [3:0] color;
   } vga_pix_t;

   typedef struct packed {
      logic [3:0] red;
      logic [3:0] green;
      logic [3:0] blue;
   } rgb12_t;

   localparam rgb12_t TMS9918_PALETTE [16] = '{
      '{red: 4'h0, green: 4'h0, blue: 4'h0},   // transparent
      '{red: 4'h0, green: 4'h0, blue: 4'h0},   // black
      '{red: 4'h2, green: 4'hc, blue: 4'h4},
      '{red: 4'h5, green: 4'hd, blue: 4'h7},
      '{red: 4'h5, green: 4'h5, blue: 4'he},   // dark blue
      '{red: 4'h7, green: 4'h7, blue: 4'hf},
      '{red: 4'hd, green: 4'h5, blue: 4'h4},
      '{red: 4'h4, green: 4'he, blue: 4'hf},   // cyan
      '{red: 4'hf, green: 4'h5, blue: 4'h5},
      '{red: 4'hf, green: 4'h7, blue: 4'h7},
      '{red: 4'hd, green: 4'hc, blue: 4'h5},
      '{red: 4'he, green: 4'hc, blue: 4'h8},
      '{red: 4'h2, green: 4'hb, blue: 4'h3},   // dark green
      '{red: 4'hc, green: 4'h5, blue: 4'hb},   // magenta
      '{red: 4'hc, green: 4'hc, blue: 4'hc},
      '{red: 4'hf, green: 4'hf, blue: 4'hf}    // white
   };

endpackage

`default_nettype wire
